//--- design/ring_err_responder.sv
//==========================================================================
// one illegal request at a time, answered with DECERR and zero data
//==========================================================================
`timescale 1ns/10ps

module ring_err_responder
  import ring_pkg::*;
(
  input  logic     clk,
  input  logic     i_reset,
  input  logic     i_err_ar_valid,
  input  ring_ar_t i_err_ar,
  output logic     o_err_ar_ready,
  output logic     o_err_r_valid,
  output ring_r_t  o_err_r,
  input  logic     i_err_r_ready
);

  logic             full;
  logic [TID_W-1:0] held_id;

  assign o_err_ar_ready = ~full;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      full <= 1'b0;
    end else if (i_err_ar_valid & ~full) begin
      full <= 1'b1;
    end else if (i_err_r_ready & full) begin
      full <= 1'b0;
    end
  end

  // stamped arid comes back as rid
  always_ff @(posedge clk) begin
    if (i_err_ar_valid & ~full) begin
      held_id <= i_err_ar.arid;
    end
  end

  assign o_err_r_valid = full;
  always_comb begin
    o_err_r.rid   = held_id;
    o_err_r.rdata = '0;
    o_err_r.rresp = RESP_DECERR;
    o_err_r.rlast = 1'b1;
  end

  a_err_r_stable: assert property (@(posedge clk) disable iff (i_reset)
    o_err_r_valid && !i_err_r_ready |=> o_err_r_valid && $stable(o_err_r));

endmodule

//--- design/ring_pkg.sv
//==========================================================================
// station id sits in the top bits of both the ring address and the tid
// ids above 23 are out of range and get a DECERR from the local station
//==========================================================================
package ring_pkg;

  // widths
  localparam int STATION_ID_W = 5;
  localparam int RING_ADDR_W  = 25;
  localparam int OFFSET_W     = RING_ADDR_W - STATION_ID_W;
  localparam int TID_W        = 8;
  localparam int DATA_W       = 32;

  // highest legal ring address
  // top 5 bits of 24 and up are illegal
  localparam logic [RING_ADDR_W-1:0] MAX_RING_ADDR = 25'h17fffff;

  // read response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // routing view of an address
  typedef struct packed {
    logic [STATION_ID_W-1:0] sid;
    logic [OFFSET_W-1:0]     offset;
  } ring_addr_fields_t;

  // flat for the limit compare, fields for routing
  typedef union packed {
    logic [RING_ADDR_W-1:0] flat;
    ring_addr_fields_t      fields;
  } ring_addr_u;

  // read request, 33 bits
  typedef struct packed {
    ring_addr_u       araddr;
    logic [TID_W-1:0] arid;
  } ring_ar_t;

  // read response, 43 bits
  typedef struct packed {
    logic [TID_W-1:0]  rid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
    logic              rlast;
  } ring_r_t;

  // home station of a transaction id
  function automatic logic [STATION_ID_W-1:0] tid_sid(logic [TID_W-1:0] tid);
    return tid[TID_W-1 -: STATION_ID_W];
  endfunction

endpackage

//--- design/ring_req_router.sv
//==========================================================================
// one registered slot per output, ring input wins a shared output
// only local requests are range checked, ring traffic is trusted
//==========================================================================
`timescale 1ns/10ps

module ring_req_router
  import ring_pkg::*;
#(
  parameter logic [STATION_ID_W-1:0] LOCAL_STATION_ID = '0
) (
  input  logic     clk,
  input  logic     i_reset,
  // from ring
  input  logic     i_ring_ar_valid,
  input  ring_ar_t i_ring_ar,
  output logic     o_ring_ar_ready,
  // from local agent
  input  logic     i_local_ar_valid,
  input  ring_ar_t i_local_ar,
  output logic     o_local_ar_ready,
  // to ring
  output logic     o_ring_ar_valid,
  output ring_ar_t o_ring_ar,
  input  logic     i_ring_ar_ready,
  // to local agent
  output logic     o_local_ar_valid,
  output ring_ar_t o_local_ar,
  input  logic     i_local_ar_ready,
  // illegal local requests
  output logic     o_err_ar_valid,
  output ring_ar_t o_err_ar,
  input  logic     i_err_ar_ready
);

  ring_ar_t local_ar_stamped;
  logic     local_err;
  logic     ring_to_local, local_to_local;
  logic     ring_free, local_free;
  logic     local_blocked;
  logic     ring_in_fire, local_in_fire;
  logic     load_ring, load_local;
  logic     ring_slot_valid, local_slot_valid;
  ring_ar_t ring_slot, local_slot;

  //========================================================================
  // decode
  //========================================================================
  // local requests carry our id home in the top arid bits
  always_comb begin
    local_ar_stamped = i_local_ar;
    local_ar_stamped.arid[TID_W-1 -: STATION_ID_W] = LOCAL_STATION_ID;
  end

  assign local_err      = i_local_ar.araddr.flat > MAX_RING_ADDR;
  assign ring_to_local  = i_ring_ar.araddr.fields.sid == LOCAL_STATION_ID;
  assign local_to_local = i_local_ar.araddr.fields.sid == LOCAL_STATION_ID;

  // slot takes a new item when empty or draining now
  assign ring_free  = ~ring_slot_valid | i_ring_ar_ready;
  assign local_free = ~local_slot_valid | i_local_ar_ready;

  //========================================================================
  // arbitration
  //========================================================================
  assign o_ring_ar_ready = ring_to_local ? local_free : ring_free;

  // local waits when ring wants the same output
  assign local_blocked = i_ring_ar_valid & (ring_to_local == local_to_local);

  assign o_local_ar_ready = local_err ? i_err_ar_ready :
                            ~local_blocked & (local_to_local ? local_free : ring_free);

  assign ring_in_fire  = i_ring_ar_valid & o_ring_ar_ready;
  assign local_in_fire = i_local_ar_valid & o_local_ar_ready & ~local_err;

  assign load_ring  = (ring_in_fire & ~ring_to_local) | (local_in_fire & ~local_to_local);
  assign load_local = (ring_in_fire & ring_to_local) | (local_in_fire & local_to_local);

  // error path is combinational, the responder registers it
  assign o_err_ar_valid = i_local_ar_valid & local_err;
  assign o_err_ar       = local_ar_stamped;

  //========================================================================
  // output slots
  //========================================================================
  always_ff @(posedge clk) begin
    if (i_reset) begin
      ring_slot_valid  <= 1'b0;
      local_slot_valid <= 1'b0;
    end else begin
      if (ring_free) begin
        ring_slot_valid <= load_ring;
      end
      if (local_free) begin
        local_slot_valid <= load_local;
      end
    end
  end

  // payload only, ring input has priority
  always_ff @(posedge clk) begin
    if (load_ring) begin
      ring_slot <= (ring_in_fire & ~ring_to_local) ? i_ring_ar : local_ar_stamped;
    end
    if (load_local) begin
      local_slot <= (ring_in_fire & ring_to_local) ? i_ring_ar : local_ar_stamped;
    end
  end

  assign o_ring_ar_valid  = ring_slot_valid;
  assign o_ring_ar        = ring_slot;
  assign o_local_ar_valid = local_slot_valid;
  assign o_local_ar       = local_slot;

  // stalled slots hold their item
  a_ring_slot_stable: assert property (@(posedge clk) disable iff (i_reset)
    o_ring_ar_valid && !i_ring_ar_ready |=> o_ring_ar_valid && $stable(o_ring_ar));
  a_local_slot_stable: assert property (@(posedge clk) disable iff (i_reset)
    o_local_ar_valid && !i_local_ar_ready |=> o_local_ar_valid && $stable(o_local_ar));

  // local slot only ever holds our own addresses
  a_local_slot_sid: assert property (@(posedge clk) disable iff (i_reset)
    o_local_ar_valid |-> o_local_ar.araddr.fields.sid == LOCAL_STATION_ID);

endmodule

//--- design/ring_resp_router.sv
//==========================================================================
// routes R by the station id in rid, error responses always go local
// priority per output is ring, then local, then error
//==========================================================================
`timescale 1ns/10ps

module ring_resp_router
  import ring_pkg::*;
#(
  parameter logic [STATION_ID_W-1:0] LOCAL_STATION_ID = '0
) (
  input  logic    clk,
  input  logic    i_reset,
  // inputs
  input  logic    i_ring_r_valid,
  input  ring_r_t i_ring_r,
  output logic    o_ring_r_ready,
  input  logic    i_local_r_valid,
  input  ring_r_t i_local_r,
  output logic    o_local_r_ready,
  input  logic    i_err_r_valid,
  input  ring_r_t i_err_r,
  output logic    o_err_r_ready,
  // outputs
  output logic    o_ring_r_valid,
  output ring_r_t o_ring_r,
  input  logic    i_ring_r_ready,
  output logic    o_local_r_valid,
  output ring_r_t o_local_r,
  input  logic    i_local_r_ready
);

  logic    ring_to_local, local_to_local;
  logic    ring_free, local_free;
  logic    ring_fire, local_fire, err_fire;
  logic    load_ring, load_local;
  logic    ring_slot_valid, local_slot_valid;
  ring_r_t ring_slot, local_slot;

  assign ring_to_local  = tid_sid(i_ring_r.rid) == LOCAL_STATION_ID;
  assign local_to_local = tid_sid(i_local_r.rid) == LOCAL_STATION_ID;

  assign ring_free  = ~ring_slot_valid | i_ring_r_ready;
  assign local_free = ~local_slot_valid | i_local_r_ready;

  //========================================================================
  // arbitration
  //========================================================================
  assign o_ring_r_ready  = ring_to_local ? local_free : ring_free;
  assign o_local_r_ready = ~(i_ring_r_valid & (ring_to_local == local_to_local)) &
                           (local_to_local ? local_free : ring_free);
  // error path loses to anything aimed at the local slot
  assign o_err_r_ready = local_free & ~(i_ring_r_valid & ring_to_local) &
                         ~(i_local_r_valid & local_to_local);

  assign ring_fire  = i_ring_r_valid & o_ring_r_ready;
  assign local_fire = i_local_r_valid & o_local_r_ready;
  assign err_fire   = i_err_r_valid & o_err_r_ready;

  assign load_ring  = (ring_fire & ~ring_to_local) | (local_fire & ~local_to_local);
  assign load_local = (ring_fire & ring_to_local) | (local_fire & local_to_local) | err_fire;

  //========================================================================
  // output slots
  //========================================================================
  always_ff @(posedge clk) begin
    if (i_reset) begin
      ring_slot_valid  <= 1'b0;
      local_slot_valid <= 1'b0;
    end else begin
      if (ring_free) begin
        ring_slot_valid <= load_ring;
      end
      if (local_free) begin
        local_slot_valid <= load_local;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_ring) begin
      ring_slot <= (ring_fire & ~ring_to_local) ? i_ring_r : i_local_r;
    end
    if (ring_fire & ring_to_local) begin
      local_slot <= i_ring_r;
    end else if (local_fire & local_to_local) begin
      local_slot <= i_local_r;
    end else if (err_fire) begin
      local_slot <= i_err_r;
    end
  end

  assign o_ring_r_valid  = ring_slot_valid;
  assign o_ring_r        = ring_slot;
  assign o_local_r_valid = local_slot_valid;
  assign o_local_r       = local_slot;

  a_ring_slot_stable: assert property (@(posedge clk) disable iff (i_reset)
    o_ring_r_valid && !i_ring_r_ready |=> o_ring_r_valid && $stable(o_ring_r));
  a_local_slot_stable: assert property (@(posedge clk) disable iff (i_reset)
    o_local_r_valid && !i_local_r_ready |=> o_local_r_valid && $stable(o_local_r));

endmodule

//--- design/ring_station.sv
//==========================================================================
// read-only ring station with a single station id
// AR latency is one cycle, local DECERR comes back two cycles after AR
//==========================================================================
`timescale 1ns/10ps

module ring_station
  import ring_pkg::*;
#(
  parameter logic [STATION_ID_W-1:0] LOCAL_STATION_ID = '0
) (
  input  logic     clk,
  input  logic     i_reset,
  // AR in
  input  logic     i_ring_ar_valid,
  input  ring_ar_t i_ring_ar,
  output logic     o_ring_ar_ready,
  input  logic     i_local_ar_valid,
  input  ring_ar_t i_local_ar,
  output logic     o_local_ar_ready,
  // AR out
  output logic     o_ring_ar_valid,
  output ring_ar_t o_ring_ar,
  input  logic     i_ring_ar_ready,
  output logic     o_local_ar_valid,
  output ring_ar_t o_local_ar,
  input  logic     i_local_ar_ready,
  // R in
  input  logic     i_ring_r_valid,
  input  ring_r_t  i_ring_r,
  output logic     o_ring_r_ready,
  input  logic     i_local_r_valid,
  input  ring_r_t  i_local_r,
  output logic     o_local_r_ready,
  // R out
  output logic     o_ring_r_valid,
  output ring_r_t  o_ring_r,
  input  logic     i_ring_r_ready,
  output logic     o_local_r_valid,
  output ring_r_t  o_local_r,
  input  logic     i_local_r_ready
);

  // error loop between the routers
  logic     err_ar_valid, err_ar_ready;
  ring_ar_t err_ar;
  logic     err_r_valid, err_r_ready;
  ring_r_t  err_r;

  ring_req_router #(.LOCAL_STATION_ID(LOCAL_STATION_ID)) req_router_i (
    .clk, .i_reset,
    .i_ring_ar_valid, .i_ring_ar, .o_ring_ar_ready,
    .i_local_ar_valid, .i_local_ar, .o_local_ar_ready,
    .o_ring_ar_valid, .o_ring_ar, .i_ring_ar_ready,
    .o_local_ar_valid, .o_local_ar, .i_local_ar_ready,
    .o_err_ar_valid (err_ar_valid),
    .o_err_ar       (err_ar),
    .i_err_ar_ready (err_ar_ready)
  );

  ring_err_responder err_responder_i (
    .clk, .i_reset,
    .i_err_ar_valid (err_ar_valid),
    .i_err_ar       (err_ar),
    .o_err_ar_ready (err_ar_ready),
    .o_err_r_valid  (err_r_valid),
    .o_err_r        (err_r),
    .i_err_r_ready  (err_r_ready)
  );

  ring_resp_router #(.LOCAL_STATION_ID(LOCAL_STATION_ID)) resp_router_i (
    .clk, .i_reset,
    .i_ring_r_valid, .i_ring_r, .o_ring_r_ready,
    .i_local_r_valid, .i_local_r, .o_local_r_ready,
    .i_err_r_valid (err_r_valid),
    .i_err_r       (err_r),
    .o_err_r_ready (err_r_ready),
    .o_ring_r_valid, .o_ring_r, .i_ring_r_ready,
    .o_local_r_valid, .o_local_r, .i_local_r_ready
  );

endmodule

//--- run.sh
#!/bin/sh
# builds the ring station testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_ring_station \
  -Mdir obj_dir

# a failing simulator exit stops the script here
out=$(./obj_dir/Vtb_ring_station)
echo "$out"

if echo "$out" | grep -q "^All checks passed$"; then
  exit 0
else
  exit 1
fi

//--- sources.f
+incdir+include
design/ring_pkg.sv
design/ring_req_router.sv
design/ring_err_responder.sv
design/ring_resp_router.sv
design/ring_station.sv
tests/tb_ring_station.sv

//--- include/tb_station_checks.svh
//==========================================================================
// include inside the testbench after dut_i and LOCAL_STATION_ID exist
// model assumes 8-bit ids and 25-bit addresses with the station id on top
//==========================================================================
`ifndef TB_STATION_CHECKS_SVH
`define TB_STATION_CHECKS_SVH

int unsigned chk_fail_count = 0;

//==========================================================================
// routing model
//==========================================================================
// station id sits in address bits 24..20
function automatic bit ar_goes_local(ring_pkg::ring_ar_t ar);
  return ar.araddr.flat[24:20] == LOCAL_STATION_ID;
endfunction

// station ids 24 to 31 have no target on the ring
function automatic bit out_of_range(ring_pkg::ring_ar_t ar);
  return ar.araddr.flat > 25'h17fffff;
endfunction

// top five arid bits carry the home station
function automatic ring_pkg::ring_ar_t stamp_local_id(ring_pkg::ring_ar_t ar);
  ring_pkg::ring_ar_t stamped;
  stamped      = ar;
  stamped.arid = {LOCAL_STATION_ID, ar.arid[2:0]};
  return stamped;
endfunction

function automatic bit response_goes_local(ring_pkg::ring_r_t r);
  return r.rid[7:3] == LOCAL_STATION_ID;
endfunction

// what the station answers for an illegal local read
function automatic ring_pkg::ring_r_t decerr_response(ring_pkg::ring_ar_t ar);
  ring_pkg::ring_ar_t stamped;
  stamped = stamp_local_id(ar);
  return '{rid: stamped.arid, rdata: '0, rresp: ring_pkg::RESP_DECERR, rlast: 1'b1};
endfunction

// normal response as the stimulus drives it
function automatic ring_pkg::ring_r_t okay_response(logic [ring_pkg::TID_W-1:0] rid,
                                                    logic [ring_pkg::DATA_W-1:0] rdata);
  return '{rid: rid, rdata: rdata, rresp: ring_pkg::RESP_OKAY, rlast: 1'b1};
endfunction

function automatic void count_failure(string what);
  chk_fail_count++;
  $display("%s at %0t ns", what, $time);
endfunction

//==========================================================================
// protocol and timing
//==========================================================================
a_reset_quiet: assert property (@(posedge dut_i.clk) dut_i.i_reset |=>
  !(dut_i.o_ring_ar_valid || dut_i.o_local_ar_valid ||
    dut_i.o_ring_r_valid || dut_i.o_local_r_valid))
  else count_failure("an output valid was high right after reset");

// outputs only carry traffic for their own side
a_ring_ar_side: assert property (@(posedge dut_i.clk) disable iff (dut_i.i_reset)
  dut_i.o_ring_ar_valid |-> !ar_goes_local(dut_i.o_ring_ar))
  else count_failure("ring AR output carried a request for this station");
a_local_ar_side: assert property (@(posedge dut_i.clk) disable iff (dut_i.i_reset)
  dut_i.o_local_ar_valid |-> ar_goes_local(dut_i.o_local_ar))
  else count_failure("local AR output carried a request for another station");
a_ring_r_side: assert property (@(posedge dut_i.clk) disable iff (dut_i.i_reset)
  dut_i.o_ring_r_valid |-> !response_goes_local(dut_i.o_ring_r))
  else count_failure("ring R output carried a response for this station");
a_local_r_side: assert property (@(posedge dut_i.clk) disable iff (dut_i.i_reset)
  dut_i.o_local_r_valid |-> response_goes_local(dut_i.o_local_r))
  else count_failure("local R output carried a response for another station");

// accepted ring request shows up one cycle later
a_ring_ar_latency: assert property (@(posedge dut_i.clk) disable iff (dut_i.i_reset)
  dut_i.i_ring_ar_valid && dut_i.o_ring_ar_ready |=>
  (ar_goes_local($past(dut_i.i_ring_ar)) ?
   dut_i.o_local_ar_valid && dut_i.o_local_ar == $past(dut_i.i_ring_ar) :
   dut_i.o_ring_ar_valid && dut_i.o_ring_ar == $past(dut_i.i_ring_ar)))
  else count_failure("accepted ring request missing from its output one cycle later");

// same for a legal local request after stamping
a_local_ar_latency: assert property (@(posedge dut_i.clk) disable iff (dut_i.i_reset)
  dut_i.i_local_ar_valid && dut_i.o_local_ar_ready && !out_of_range(dut_i.i_local_ar)
  |=> (ar_goes_local($past(dut_i.i_local_ar)) ?
   dut_i.o_local_ar_valid && dut_i.o_local_ar == stamp_local_id($past(dut_i.i_local_ar)) :
   dut_i.o_ring_ar_valid && dut_i.o_ring_ar == stamp_local_id($past(dut_i.i_local_ar))))
  else count_failure("accepted local request missing from its output one cycle later");

// uncontended DECERR two cycles after the AR handshake
a_err_latency: assert property (@(posedge dut_i.clk) disable iff (dut_i.i_reset)
  $past(dut_i.i_local_ar_valid && dut_i.o_local_ar_ready &&
        out_of_range(dut_i.i_local_ar)) && dut_i.err_r_ready |=>
  dut_i.o_local_r_valid && dut_i.o_local_r == decerr_response($past(dut_i.i_local_ar, 2)))
  else count_failure("DECERR response missing two cycles after its request");

`endif

//--- tests/tb_ring_station.sv
//==========================================================================
// station id 5, ring side sends legal addresses only, local side also 24..31
// outputs are sampled on the falling edge, inputs change 2 ns after rising
//==========================================================================
`timescale 1ns/10ps

module tb_ring_station
  import ring_pkg::*;
();

  localparam logic [STATION_ID_W-1:0] LOCAL_STATION_ID = 5'd5;
  localparam int PERIOD_NS     = 40;
  localparam int RESET_CYCLES  = 5;
  localparam int DIRECT_CYCLES = 20;
  localparam int RANDOM_CYCLES = 3000;
  localparam int DRAIN_CYCLES  = 60;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + DIRECT_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
  localparam int MARGIN_CYCLES = 200;

  logic     clk = 1'b0;
  logic     i_reset;
  logic     i_ring_ar_valid, i_local_ar_valid, i_ring_r_valid, i_local_r_valid;
  ring_ar_t i_ring_ar, i_local_ar;
  ring_r_t  i_ring_r, i_local_r;
  logic     o_ring_ar_ready, o_local_ar_ready, o_ring_r_ready, o_local_r_ready;
  logic     o_ring_ar_valid, o_local_ar_valid, o_ring_r_valid, o_local_r_valid;
  ring_ar_t o_ring_ar, o_local_ar;
  ring_r_t  o_ring_r, o_local_r;
  logic     i_ring_ar_ready, i_local_ar_ready, i_ring_r_ready, i_local_r_ready;

  // input handshakes seen on the last falling edge
  logic     ring_ar_fire, local_ar_fire, ring_r_fire, local_r_fire;
  ring_ar_t stamped_ar;

  // expected items per output with DECERR responses in a queue of their own
  ring_ar_t exp_ring_ar[$], exp_local_ar[$];
  ring_r_t  exp_ring_r[$], exp_local_r[$], exp_err_r[$];

  int unsigned check_count = 0;
  int unsigned tests_done  = 0;

  always #(PERIOD_NS / 2) clk = ~clk;

  ring_station #(.LOCAL_STATION_ID(LOCAL_STATION_ID)) dut_i (.*);

  `include "tb_station_checks.svh"

  function automatic void check_value(string name, logic [63:0] got, logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      chk_fail_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endfunction

  function automatic void unexpected(string name);
    chk_fail_count++;
    $display("%s carried an item that no accepted input explains, at %0t ns", name, $time);
  endfunction

  // station id picks local, other legal or (local side only) out of range
  function automatic ring_addr_u pick_addr(bit allow_illegal);
    ring_addr_u  a;
    int unsigned pick;
    pick   = $urandom % 8;
    a.flat = RING_ADDR_W'($urandom);
    if (pick < 3) begin
      a.fields.sid = LOCAL_STATION_ID;
    end else if (pick < 6 || !allow_illegal) begin
      a.fields.sid = STATION_ID_W'($urandom % 24);
    end else begin
      a.fields.sid = STATION_ID_W'(24 + $urandom % 8);
    end
    return a;
  endfunction

  function automatic logic [TID_W-1:0] random_rid();
    logic [STATION_ID_W-1:0] sid;
    sid = ($urandom % 2 == 0) ? LOCAL_STATION_ID : STATION_ID_W'($urandom);
    return {sid, 3'($urandom)};
  endfunction

  function automatic ring_ar_t build_ar(logic [STATION_ID_W-1:0] sid, logic [TID_W-1:0] arid);
    ring_ar_t ar;
    ar.araddr.fields.sid    = sid;
    ar.araddr.fields.offset = OFFSET_W'($urandom);
    ar.arid                 = arid;
    return ar;
  endfunction

  //========================================================================
  // scoreboard
  //========================================================================
  always @(negedge clk) begin
    ring_ar_fire  = !i_reset && i_ring_ar_valid && o_ring_ar_ready;
    local_ar_fire = !i_reset && i_local_ar_valid && o_local_ar_ready;
    ring_r_fire   = !i_reset && i_ring_r_valid && o_ring_r_ready;
    local_r_fire  = !i_reset && i_local_r_valid && o_local_r_ready;
    // drain before push since the slot item is always older than a new input
    if (!i_reset && o_ring_ar_valid && i_ring_ar_ready) begin
      if (exp_ring_ar.size() == 0) begin
        unexpected("o_ring_ar");
      end else begin
        check_value("o_ring_ar", 64'(o_ring_ar), 64'(exp_ring_ar.pop_front()));
      end
    end
    if (!i_reset && o_local_ar_valid && i_local_ar_ready) begin
      if (exp_local_ar.size() == 0) begin
        unexpected("o_local_ar");
      end else begin
        check_value("o_local_ar", 64'(o_local_ar), 64'(exp_local_ar.pop_front()));
      end
    end
    if (!i_reset && o_ring_r_valid && i_ring_r_ready) begin
      if (exp_ring_r.size() == 0) begin
        unexpected("o_ring_r");
      end else begin
        check_value("o_ring_r", 64'(o_ring_r), 64'(exp_ring_r.pop_front()));
      end
    end
    if (!i_reset && o_local_r_valid && i_local_r_ready) begin
      if (o_local_r.rresp == RESP_DECERR && exp_err_r.size() != 0) begin
        check_value("o_local_r", 64'(o_local_r), 64'(exp_err_r.pop_front()));
      end else if (exp_local_r.size() == 0) begin
        unexpected("o_local_r");
      end else begin
        check_value("o_local_r", 64'(o_local_r), 64'(exp_local_r.pop_front()));
      end
    end
    // ring and local never share an output in one cycle
    if (ring_ar_fire) begin
      if (ar_goes_local(i_ring_ar)) begin
        exp_local_ar.push_back(i_ring_ar);
      end else begin
        exp_ring_ar.push_back(i_ring_ar);
      end
    end
    if (local_ar_fire) begin
      stamped_ar = stamp_local_id(i_local_ar);
      if (out_of_range(i_local_ar)) begin
        exp_err_r.push_back(decerr_response(i_local_ar));
      end else if (ar_goes_local(i_local_ar)) begin
        exp_local_ar.push_back(stamped_ar);
      end else begin
        exp_ring_ar.push_back(stamped_ar);
      end
    end
    if (ring_r_fire) begin
      if (response_goes_local(i_ring_r)) begin
        exp_local_r.push_back(i_ring_r);
      end else begin
        exp_ring_r.push_back(i_ring_r);
      end
    end
    if (local_r_fire) begin
      if (response_goes_local(i_local_r)) begin
        exp_local_r.push_back(i_local_r);
      end else begin
        exp_ring_r.push_back(i_local_r);
      end
    end
  end

  //========================================================================
  // stimulus
  //========================================================================
  task automatic set_readies(bit all_high);
    i_ring_ar_ready  = all_high || ($urandom % 4 != 0);
    i_local_ar_ready = all_high || ($urandom % 4 != 0);
    i_ring_r_ready   = all_high || ($urandom % 4 != 0);
    i_local_r_ready  = all_high || ($urandom % 4 != 0);
  endtask

  // a pending input keeps valid and payload until it is taken
  task automatic drive_inputs(bit make_new);
    if (!i_ring_ar_valid || ring_ar_fire) begin
      i_ring_ar_valid  = make_new && ($urandom % 3 == 0);
      i_ring_ar.araddr = pick_addr(1'b0);
      i_ring_ar.arid   = TID_W'($urandom);
    end
    if (!i_local_ar_valid || local_ar_fire) begin
      i_local_ar_valid  = make_new && ($urandom % 3 == 0);
      i_local_ar.araddr = pick_addr(1'b1);
      i_local_ar.arid   = TID_W'($urandom);
    end
    if (!i_ring_r_valid || ring_r_fire) begin
      i_ring_r_valid = make_new && ($urandom % 3 == 0);
      i_ring_r       = okay_response(random_rid(), $urandom);
    end
    if (!i_local_r_valid || local_r_fire) begin
      i_local_r_valid = make_new && ($urandom % 3 == 0);
      i_local_r       = okay_response(random_rid(), $urandom);
    end
  endtask

  // one request on an idle station and its valid lat cycles after AR
  task automatic latency_case(ring_ar_t ar, bit from_ring, int lat);
    logic  got;
    string name;
    @(posedge clk);
    #2;
    if (from_ring) begin
      i_ring_ar       = ar;
      i_ring_ar_valid = 1'b1;
    end else begin
      i_local_ar       = ar;
      i_local_ar_valid = 1'b1;
    end
    @(posedge clk);
    #2;
    i_ring_ar_valid  = 1'b0;
    i_local_ar_valid = 1'b0;
    repeat (lat - 1) @(posedge clk);
    @(negedge clk);
    if (!from_ring && out_of_range(ar)) begin
      name = "o_local_r_valid";
      got  = o_local_r_valid;
    end else if (ar_goes_local(ar)) begin
      name = "o_local_ar_valid";
      got  = o_local_ar_valid;
    end else begin
      name = "o_ring_ar_valid";
      got  = o_ring_ar_valid;
    end
    check_value(name, 64'(got), 64'(1));
  endtask

  function automatic bit traffic_pending();
    return i_ring_ar_valid || i_local_ar_valid || i_ring_r_valid || i_local_r_valid ||
           exp_ring_ar.size() != 0 || exp_local_ar.size() != 0 ||
           exp_ring_r.size() != 0 || exp_local_r.size() != 0 || exp_err_r.size() != 0;
  endfunction

  task automatic finish_test(string name);
    tests_done++;
    $display("test %s finished, %0d failures so far", name, chk_fail_count);
  endtask

  task automatic expect_outputs_idle();
    check_value("o_ring_ar_valid", 64'(o_ring_ar_valid), 64'(0));
    check_value("o_local_ar_valid", 64'(o_local_ar_valid), 64'(0));
    check_value("o_ring_r_valid", 64'(o_ring_r_valid), 64'(0));
    check_value("o_local_r_valid", 64'(o_local_r_valid), 64'(0));
  endtask

  initial begin
    void'($urandom(18));
    i_reset          = 1'b1;
    i_ring_ar_valid  = 1'b0;
    i_local_ar_valid = 1'b0;
    i_ring_r_valid   = 1'b0;
    i_local_r_valid  = 1'b0;
    i_ring_ar        = '0;
    i_local_ar       = '0;
    i_ring_r         = '0;
    i_local_r        = '0;
    set_readies(1'b1);
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    i_reset = 1'b0;
    @(negedge clk);
    expect_outputs_idle();
    finish_test("reset");

    // each route once with nothing else in flight
    latency_case(build_ar(LOCAL_STATION_ID, 8'h11), 1'b1, 1);
    latency_case(build_ar(5'd3, 8'h22), 1'b1, 1);
    latency_case(build_ar(LOCAL_STATION_ID, 8'h33), 1'b0, 1);
    latency_case(build_ar(5'd12, 8'h44), 1'b0, 1);
    latency_case(build_ar(5'd27, 8'h55), 1'b0, 2);
    finish_test("latency");

    repeat (RANDOM_CYCLES) begin
      @(posedge clk);
      #2;
      drive_inputs(1'b1);
      set_readies(1'b0);
    end
    finish_test("random");

    // stop new traffic and let every accepted item come out
    do begin
      @(posedge clk);
      #2;
      drive_inputs(1'b0);
      set_readies(1'b1);
      @(negedge clk);
    end while (traffic_pending());
    repeat (3) @(negedge clk);
    expect_outputs_idle();
    finish_test("drain");

    $display("%0d tests, %0d checks, %0d failures", tests_done, check_count, chk_fail_count);
    if (chk_fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // bound of four periods per stimulus cycle
  initial begin
    #((TOTAL_CYCLES * 4 + MARGIN_CYCLES) * PERIOD_NS);
    $display("watchdog expired before the traffic drained");
    $display("Checks failed");
    $finish;
  end

endmodule
